/* design/amem_pkg.sv */
// A-memory shared definitions

package amem_pkg;

   // data path and storage geometry.
   localparam int amem_data_w = 32;
   localparam int amem_addr_w = 10;
   localparam int amem_depth  = 1024;

   // command opcodes.
   // the three-bit field leaves code 7 unused.
   typedef enum logic [2:0]
   {
      op_write = 3'd0, // cmd_data goes to dst.
      op_read  = 3'd1, // returns mem[src_a] and writes nothing.
      op_add   = 3'd2, // mem[src_a] + mem[src_b] goes to dst.
      op_sub   = 3'd3, // mem[src_a] - mem[src_b], modulo 2^32.
      op_and   = 3'd4,
      op_or    = 3'd5,
      op_xor   = 3'd6
   } amem_op_e;

endpackage

/* design/amem_dpram.sv */
// A-memory scratchpad RAM

`timescale 1ns/1ps

module amem_dpram
   import amem_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   rd_en,
   input  logic [amem_addr_w-1:0] rd_addr_a,
   input  logic [amem_addr_w-1:0] rd_addr_b,
   input  logic                   wr_en,
   input  logic [amem_addr_w-1:0] wr_addr,
   input  logic [amem_data_w-1:0] wr_data,
   output logic [amem_data_w-1:0] q_a,
   output logic [amem_data_w-1:0] q_b
);

   logic [amem_data_w-1:0] mem [amem_depth];

   logic [amem_data_w-1:0] out_a;
   logic [amem_data_w-1:0] out_b;

   // single write port.
   always_ff @(posedge clk_a)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // a read that hits the address being written sees the old word.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_a <= '0;
         out_b <= '0;
      end
      else if (rd_en)
      begin
         out_a <= mem[rd_addr_a];
         out_b <= mem[rd_addr_b];
      end
   end

   assign q_a = out_a;
   assign q_b = out_b;

endmodule

/* design/amem_pipeline.sv */
// A-memory command pipeline

`timescale 1ns/1ps

module amem_pipeline
   import amem_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   cmd_valid,
   input  amem_op_e               cmd_op,
   input  logic [amem_addr_w-1:0] cmd_dst,
   input  logic [amem_addr_w-1:0] cmd_src_a,
   input  logic [amem_addr_w-1:0] cmd_src_b,
   input  logic [amem_data_w-1:0] cmd_data,
   input  logic [amem_data_w-1:0] q_a,
   input  logic [amem_data_w-1:0] q_b,
   input  logic                   res_pending,
   input  logic [amem_addr_w-1:0] res_dst,
   input  logic [amem_data_w-1:0] res_data,
   input  logic                   wb_valid,
   input  logic [amem_addr_w-1:0] wb_dst,
   input  logic [amem_data_w-1:0] wb_data,
   output logic                   rd_en,
   output logic [amem_addr_w-1:0] rd_addr_a,
   output logic [amem_addr_w-1:0] rd_addr_b,
   output logic                   ex_valid,
   output amem_op_e               ex_op,
   output logic [amem_addr_w-1:0] ex_dst,
   output logic [amem_data_w-1:0] ex_data,
   output logic [amem_data_w-1:0] operand_a,
   output logic [amem_data_w-1:0] operand_b
);

   logic [amem_addr_w-1:0] ex_src_a;
   logic [amem_addr_w-1:0] ex_src_b;

   // the RAM registers its reads at the same edge as the execute stage.
   assign rd_en     = cmd_valid;
   assign rd_addr_a = cmd_src_a;
   assign rd_addr_b = cmd_src_b;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         ex_valid <= 1'b0;
      else
         ex_valid <= cmd_valid;
   end

   always_ff @(posedge clk_a)
   begin
      if (cmd_valid)
      begin
         ex_op    <= cmd_op;
         ex_dst   <= cmd_dst;
         ex_data  <= cmd_data;
         ex_src_a <= cmd_src_a;
         ex_src_b <= cmd_src_b;
      end
   end

   // Operand select for one source address.
   // The result one command ahead is newer than the word written two ahead.
   function automatic logic [amem_data_w-1:0] fwd_operand
   (
      input logic [amem_addr_w-1:0] src,
      input logic [amem_data_w-1:0] ram_q
   );
      logic [amem_data_w-1:0] sel;
      if (res_pending && (res_dst == src))
         sel = res_data;
      else if (wb_valid && (wb_dst == src))
         sel = wb_data; // this write collided with our read.
      else
         sel = ram_q;
      return sel;
   endfunction

   always_comb
   begin
      operand_a = fwd_operand(ex_src_a, q_a);
      operand_b = fwd_operand(ex_src_b, q_b);
   end

endmodule

/* design/amem_alu.sv */
// A-memory ALU and writeback

`timescale 1ns/1ps

module amem_alu
   import amem_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   ex_valid,
   input  amem_op_e               ex_op,
   input  logic [amem_addr_w-1:0] ex_dst,
   input  logic [amem_data_w-1:0] ex_data,
   input  logic [amem_data_w-1:0] operand_a,
   input  logic [amem_data_w-1:0] operand_b,
   output logic                   result_valid,
   output logic [amem_data_w-1:0] result_data,
   output logic                   res_pending,
   output logic [amem_addr_w-1:0] res_dst,
   output logic [amem_data_w-1:0] res_data,
   output logic                   wr_en,
   output logic [amem_addr_w-1:0] wr_addr,
   output logic [amem_data_w-1:0] wr_data,
   output logic                   wb_valid,
   output logic [amem_addr_w-1:0] wb_dst,
   output logic [amem_data_w-1:0] wb_data
);

   logic [amem_data_w-1:0] alu_out;
   logic [amem_data_w-1:0] result_q;

   always_comb
   begin
      case (ex_op)
         op_write: alu_out = ex_data;
         op_read:  alu_out = operand_a;
         op_add:   alu_out = operand_a + operand_b;
         op_sub:   alu_out = operand_a - operand_b; // wraps modulo 2^32.
         op_and:   alu_out = operand_a & operand_b;
         op_or:    alu_out = operand_a | operand_b;
         op_xor:   alu_out = operand_a ^ operand_b;
         default:  alu_out = ex_data;
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         result_valid <= 1'b0;
         res_pending  <= 1'b0;
         wb_valid     <= 1'b0;
      end
      else
      begin
         result_valid <= ex_valid;
         res_pending  <= ex_valid && (ex_op != op_read); // reads write nothing back.
         wb_valid     <= res_pending;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (ex_valid)
      begin
         result_q <= alu_out;
         res_dst  <= ex_dst;
      end
      if (res_pending)
      begin
         wb_dst  <= res_dst; // the word the RAM takes at this edge.
         wb_data <= result_q;
      end
   end

   assign result_data = result_q;
   assign res_data    = result_q;

   // the pending result is written at the next edge.
   assign wr_en   = res_pending;
   assign wr_addr = res_dst;
   assign wr_data = result_q;

endmodule

/* design/amem_top.sv */
// A-memory subsystem top

`timescale 1ns/1ps

module amem_top
   import amem_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   cmd_valid,
   input  amem_op_e               cmd_op,
   input  logic [amem_addr_w-1:0] cmd_dst,
   input  logic [amem_addr_w-1:0] cmd_src_a,
   input  logic [amem_addr_w-1:0] cmd_src_b,
   input  logic [amem_data_w-1:0] cmd_data,
   output logic                   result_valid,
   output logic [amem_data_w-1:0] result_data
);

   logic                   rd_en;
   logic [amem_addr_w-1:0] rd_addr_a;
   logic [amem_addr_w-1:0] rd_addr_b;
   logic [amem_data_w-1:0] q_a;
   logic [amem_data_w-1:0] q_b;
   logic                   ex_valid;
   amem_op_e               ex_op;
   logic [amem_addr_w-1:0] ex_dst;
   logic [amem_data_w-1:0] ex_data;
   logic [amem_data_w-1:0] operand_a;
   logic [amem_data_w-1:0] operand_b;
   logic                   wr_en;
   logic [amem_addr_w-1:0] wr_addr;
   logic [amem_data_w-1:0] wr_data;
   logic                   res_pending;
   logic [amem_addr_w-1:0] res_dst;
   logic [amem_data_w-1:0] res_data;
   logic                   wb_valid;
   logic [amem_addr_w-1:0] wb_dst;
   logic [amem_data_w-1:0] wb_data;

   amem_dpram ram0 (.*);

   amem_pipeline pipe0 (.*);

   amem_alu alu0 (.*);

endmodule

/* dv/amem_tb.sv */
// A-memory subsystem testbench

`timescale 1ns/1ps

module amem_tb
   import amem_pkg::*;
;

   localparam logic [amem_addr_w-1:0] window_base = 10'h1f8; // 8-word hazard window.
   localparam int drain_limit = 20;

   logic                   clk_a = 1'b0;
   logic                   reset;
   logic                   cmd_valid;
   amem_op_e               cmd_op;
   logic [amem_addr_w-1:0] cmd_dst;
   logic [amem_addr_w-1:0] cmd_src_a;
   logic [amem_addr_w-1:0] cmd_src_b;
   logic [amem_data_w-1:0] cmd_data;
   logic                   result_valid;
   logic [amem_data_w-1:0] result_data;

   logic [amem_data_w-1:0] model_mem [amem_depth];
   logic [amem_data_w-1:0] exp_data_q [$];
   int                     exp_cycle_q [$];
   logic [31:0]            rng_state = 32'h5e1e4f74;
   int                     cycle_count = 0;
   int                     error_count = 0;
   int                     unexpected_count = 0;
   int                     missing_count = 0;

   amem_top dut0 (.*);

   always #10 clk_a = ~clk_a;

   always @(posedge clk_a)
      cycle_count <= cycle_count + 1;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [amem_addr_w-1:0] win_addr(input logic [31:0] r);
      return window_base + {7'd0, r[27:25]}; // upper bits of the LCG are the better ones.
   endfunction

   // expected result of one command, given the words it reads.
   function automatic logic [amem_data_w-1:0] model_result
   (
      input amem_op_e               op,
      input logic [amem_data_w-1:0] a,
      input logic [amem_data_w-1:0] b,
      input logic [amem_data_w-1:0] imm
   );
      case (op)
         op_write: return imm;
         op_read:  return a;
         op_add:   return a + b;
         op_sub:   return a - b;
         op_and:   return a & b;
         op_or:    return a | b;
         op_xor:   return a ^ b;
         default:  return 'x;
      endcase
   endfunction

   task automatic check_value
   (
      input string       name,
      input logic [31:0] got,
      input logic [31:0] expected
   );
      if (got !== expected)
      begin
         error_count++;
         $display("error at %0t: %s got %h expected %h", $time, name, got, expected);
      end
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the next one.
   task automatic issue_cmd
   (
      input amem_op_e               op,
      input logic [amem_addr_w-1:0] dst,
      input logic [amem_addr_w-1:0] src_a,
      input logic [amem_addr_w-1:0] src_b,
      input logic [amem_data_w-1:0] data
   );
      logic [amem_data_w-1:0] expected;
      expected = model_result(op, model_mem[src_a], model_mem[src_b], data);
      if (op != op_read)
         model_mem[dst] = expected;
      exp_data_q.push_back(expected);
      exp_cycle_q.push_back(cycle_count + 2); // result sits between E1 and E2.
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_dst   = dst;
      cmd_src_a = src_a;
      cmd_src_b = src_b;
      cmd_data  = data;
      @(posedge clk_a);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n)
         @(posedge clk_a);
      #1;
   endtask

   // results are sampled mid-cycle, away from the edges.
   always @(negedge clk_a)
   begin
      if (!reset)
      begin
         if (result_valid !== 1'b0)
         begin
            if (exp_data_q.size() == 0)
            begin
               unexpected_count++;
               $display("error at %0t: result pulse with no command outstanding", $time);
            end
            else
            begin
               check_value("result_data", result_data, exp_data_q.pop_front());
               check_value("result cycle", cycle_count, exp_cycle_q.pop_front());
            end
         end
         else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle_count)
         begin
            missing_count++;
            $display("error at %0t: no result for the command due in cycle %0d",
                     $time, exp_cycle_q[0]);
            void'(exp_data_q.pop_front());
            void'(exp_cycle_q.pop_front());
         end
      end
   end

   initial
   begin
      logic [31:0] r;
      amem_op_e    op;
      int          timeout;
      reset     = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = op_write;
      cmd_dst   = '0;
      cmd_src_a = '0;
      cmd_src_b = '0;
      cmd_data  = '0;
      repeat (2)
         @(posedge clk_a);
      #1;
      reset = 1'b0;
      idle(4); // any pulse here has no command behind it.

      for (int i = 0; i < 8; i++) // the RAM is not reset, so fill the window first.
         issue_cmd(op_write, window_base + 10'(i), '0, '0, next_rand());
      idle(3);

      issue_cmd(op_write, window_base + 10'd2, '0, '0, 32'hcafe_0123);
      idle(2);
      issue_cmd(op_read, window_base, window_base + 10'd2, '0, '0);
      issue_cmd(op_read, window_base + 10'd2, window_base, '0, '0);
      idle(1);

      issue_cmd(op_write, window_base + 10'd3, '0, '0, 32'd3);
      issue_cmd(op_write, window_base + 10'd4, '0, '0, 32'd10);
      idle(2);
      issue_cmd(op_sub, window_base + 10'd5, window_base + 10'd3, window_base + 10'd4, '0);
      idle(2);
      issue_cmd(op_add, window_base + 10'd6, window_base + 10'd5, window_base + 10'd4, '0);
      idle(3);
      issue_cmd(op_and, window_base + 10'd7, window_base + 10'd2, window_base + 10'd6, '0);
      idle(3);
      issue_cmd(op_or, window_base + 10'd1, window_base + 10'd2, window_base + 10'd5, '0);
      idle(3);
      issue_cmd(op_xor, window_base + 10'd0, window_base + 10'd1, window_base + 10'd7, '0);
      idle(3);

      issue_cmd(op_write, window_base, '0, '0, 32'h1111_0001);
      issue_cmd(op_add, window_base, window_base, window_base, '0); // one ahead.
      issue_cmd(op_add, window_base, window_base, window_base, '0);
      issue_cmd(op_write, window_base + 10'd1, '0, '0, 32'h0f0f_00ff);
      issue_cmd(op_read, window_base + 10'd6, window_base + 10'd6, '0, '0);
      issue_cmd(op_add, window_base + 10'd1, window_base + 10'd1, window_base + 10'd1, '0);
      issue_cmd(op_write, window_base + 10'd4, '0, '0, 32'h0000_0007);
      issue_cmd(op_write, window_base + 10'd4, '0, '0, 32'h8000_0009);
      issue_cmd(op_add, window_base + 10'd4, window_base + 10'd4, window_base + 10'd4, '0);
      issue_cmd(op_write, window_base + 10'd5, '0, '0, 32'h0000_0100);
      idle(1);
      issue_cmd(op_sub, window_base + 10'd6, window_base + 10'd5, window_base + 10'd4, '0);
      idle(3);

      for (int i = 0; i < 2000; i++)
      begin
         r  = next_rand();
         op = amem_op_e'(3'(r[31:16] % 16'd7));
         issue_cmd(op, win_addr(next_rand()), win_addr(next_rand()), win_addr(next_rand()),
                   next_rand());
         r = next_rand();
         if (r[31:30] == 2'b00)
            idle(int'(r[29:28]) + 1); // a gap now and then.
      end

      timeout = 0;
      while (exp_data_q.size() != 0 && timeout < drain_limit)
      begin
         @(posedge clk_a);
         timeout++;
      end
      if (exp_data_q.size() != 0)
      begin
         $display("timeout: %0d results never arrived", exp_data_q.size());
         missing_count += exp_data_q.size();
      end
      idle(4);

      $display("mismatches %0d, unexpected results %0d, missing results %0d",
               error_count, unexpected_count, missing_count);
      if (error_count == 0 && unexpected_count == 0 && missing_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* sim.f */
design/amem_pkg.sv
design/amem_dpram.sv
design/amem_pipeline.sv
design/amem_alu.sv
design/amem_top.sv
dv/amem_tb.sv

/* Makefile */
# Verilator build and run for the A-memory subsystem

VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= amem_tb
RTL_TOP   ?= amem_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

RTL_SRCS := $(filter design/%,$(shell cat $(FILELIST)))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
